//--- testbench/alu_golden.hex
// op s1 s2 result flags, flags bit 2 lt, bit 1 ltu, bit 0 eq
// a line with op ffffffff ends the list
0 7fffffff 00000001 80000000 0
1 00000000 00000001 ffffffff 6
2 f0f0f0f0 ff00ff00 f000f000 6
3 f0f0f0f0 0f0f0f0f ffffffff 4
4 12345678 12345678 00000000 1
5 ffffffff 00000001 00000001 4
6 ffffffff 00000001 00000000 4
5 00000005 00000005 00000000 1
6 00000001 80000000 00000001 2
7 00000001 00000020 00000001 6
7 00000001 00000001 00000002 1
7 00000003 0000001f 80000000 6
8 80000000 0000001f 00000001 4
8 80000000 00000021 40000000 4
9 80000000 0000001f ffffffff 4
9 f0000000 00000001 f8000000 4
9 7ffffff0 00000004 07ffffff 0
a fffffffe 00000003 fffffffa 4
b fffffffe 00000003 ffffffff 4
b 80000000 80000000 40000000 1
c ffffffff ffffffff ffffffff 1
d ffffffff ffffffff fffffffe 1
a 12345678 00010000 56780000 0
c 00000002 80000000 00000001 2
d 80000000 00000004 00000002 4
e 00000003 00000004 00000007 6
1 80000000 00000001 7fffffff 4
ffffffff 00000000 00000000 00000000 0

//--- tb.f
common/alu_pkg.sv
alu/alu_mul.sv
alu/alu_core.sv
logic/op_queue.sv
logic/issue_ctrl.sv
logic/exec_unit.sv
testbench/exec_checker.sv
testbench/tb_exec_unit.sv

//--- run_sim.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_exec_unit -f tb.f -o sim_exec_unit
./obj_dir/sim_exec_unit | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

//--- testbench/tb_exec_unit.sv
`timescale 1ns/100ps

module tb_exec_unit import alu_pkg::*; ();

    localparam int          CLK_PERIOD        = 40;
    localparam int          RESET_CYCLES      = 10;
    localparam int          MAX_VECTORS       = 64;
    localparam int          VEC_WORDS         = 5;
    localparam int          CYCLES_PER_VECTOR = 40;
    localparam int          SLACK_CYCLES      = 100;
    localparam int          DRAIN_CYCLES      = 50;
    localparam logic [31:0] END_MARK          = 32'hffffffff;

    logic               I_clk;
    logic               I_reset;
    logic               push;
    logic [ALUOP_W-1:0] aluop;
    logic [XLEN-1:0]    s1;
    logic [XLEN-1:0]    s2;
    logic               full;
    logic               result_valid;
    logic [XLEN-1:0]    result;
    logic               lt;
    logic               ltu;
    logic               eq;

    logic [31:0] golden [VEC_WORDS*MAX_VECTORS];
    int          vec_count;
    int          seed_draw;
    logic        check_done;
    int          seen_count;
    int          pass_count;
    int          fail_count;
    int          error_count;

    exec_unit u_exec_unit (
        .I_clk          (I_clk),
        .I_reset        (I_reset),
        .I_push         (push),
        .I_aluop        (aluop),
        .I_s1           (s1),
        .I_s2           (s2),
        .O_full         (full),
        .O_result_valid (result_valid),
        .O_result       (result),
        .O_lt           (lt),
        .O_ltu          (ltu),
        .O_eq           (eq)
    );

    exec_checker u_exec_checker (
        .I_clk        (I_clk),
        .I_reset      (I_reset),
        .result_valid (result_valid),
        .result       (result),
        .lt           (lt),
        .ltu          (ltu),
        .eq           (eq),
        .full         (full),
        .done         (check_done),
        .seen_count   (seen_count),
        .pass_count   (pass_count),
        .fail_count   (fail_count),
        .error_count  (error_count)
    );

    initial begin
        I_clk = 1'b0;
        forever #(CLK_PERIOD/2) I_clk = ~I_clk;
    end

    // random idle gap, then push once the queue has room
    task automatic push_vector(input int idx);
        int gap;
        gap = int'($urandom % 4);
        repeat (gap) @(posedge I_clk);
        @(negedge I_clk);
        while (full) begin
            @(negedge I_clk);
        end
        @(posedge I_clk);
        push  <= 1'b1;
        aluop <= golden[VEC_WORDS*idx][ALUOP_W-1:0];
        s1    <= golden[VEC_WORDS*idx+1];
        s2    <= golden[VEC_WORDS*idx+2];
        @(posedge I_clk);
        push <= 1'b0;
    endtask

    task automatic report_counts();
        $display("vectors %0d, passed %0d, failed %0d, other errors %0d",
                 vec_count, pass_count, fail_count, error_count);
    endtask

    initial begin
        I_reset <= 1'b1;
        push    <= 1'b0;
        aluop   <= '0;
        s1      <= '0;
        s2      <= '0;
        seed_draw = $urandom(24);
        vec_count = 0;
        $readmemh("testbench/alu_golden.hex", golden);
        while (vec_count < MAX_VECTORS && golden[VEC_WORDS*vec_count] != END_MARK) begin
            vec_count++;
        end
        if (vec_count == 0) begin
            $display("no vectors were read from testbench/alu_golden.hex");
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge I_clk);
            I_reset <= 1'b0;
            for (int i = 0; i < vec_count; i++) begin
                push_vector(i);
            end
        end
    end

    // watchdog scaled by the vector count
    initial begin
        @(posedge I_clk);
        repeat (RESET_CYCLES + vec_count*CYCLES_PER_VECTOR + SLACK_CYCLES) @(posedge I_clk);
        $display("timeout: only %0d of %0d results arrived, the rest are missing",
                 seen_count, vec_count);
        report_counts();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        wait (check_done === 1'b1);
        // late extra pulses are still caught by the checker here
        repeat (DRAIN_CYCLES) @(posedge I_clk);
        report_counts();
        if (fail_count == 0 && error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/exec_checker.sv
`timescale 1ns/100ps

module exec_checker import alu_pkg::*; (
    input  logic            I_clk,
    input  logic            I_reset,
    input  logic            result_valid,
    input  logic [XLEN-1:0] result,
    input  logic            lt,
    input  logic            ltu,
    input  logic            eq,
    input  logic            full,
    output logic            done,
    output int              seen_count,
    output int              pass_count,
    output int              fail_count,
    output int              error_count
);

    localparam int          MAX_VECTORS = 64;
    localparam int          VEC_WORDS   = 5;
    localparam logic [31:0] END_MARK    = 32'hffffffff;

    logic [31:0] golden [VEC_WORDS*MAX_VECTORS];
    int          vec_count;
    logic        seen_full;

    initial begin
        vec_count = 0;
        $readmemh("testbench/alu_golden.hex", golden);
        while (vec_count < MAX_VECTORS && golden[VEC_WORDS*vec_count] != END_MARK) begin
            vec_count++;
        end
    end

    function automatic int value_mismatch(input int idx, input string name,
                                          input logic [XLEN-1:0] expected,
                                          input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t vector %0d %s expected %h actual %h",
                     $time, idx, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    // outputs are stable at the falling edge
    always @(negedge I_clk) begin : sample
        int base;
        int wrong;
        if (I_reset) begin
            done        = 1'b0;
            seen_full   = 1'b0;
            seen_count  = 0;
            pass_count  = 0;
            fail_count  = 0;
            error_count = 0;
        end else begin
            if (full) begin
                seen_full = 1'b1;
            end
            if (result_valid) begin
                if (seen_count >= vec_count) begin
                    $display("result valid pulsed at %0t with no vector left to compare",
                             $time);
                    error_count++;
                end else begin
                    base  = VEC_WORDS*seen_count;
                    wrong = 0;
                    wrong += value_mismatch(seen_count, "O_result", golden[base+3], result);
                    wrong += value_mismatch(seen_count, "O_lt",
                                            XLEN'(golden[base+4][2]), XLEN'(lt));
                    wrong += value_mismatch(seen_count, "O_ltu",
                                            XLEN'(golden[base+4][1]), XLEN'(ltu));
                    wrong += value_mismatch(seen_count, "O_eq",
                                            XLEN'(golden[base+4][0]), XLEN'(eq));
                    if (wrong == 0) begin
                        $display("[PASS] %0t vector %0d op %0d result %h",
                                 $time, seen_count, golden[base], result);
                        pass_count++;
                    end else begin
                        fail_count++;
                    end
                    seen_count++;
                    if (seen_count == vec_count) begin
                        if (!seen_full) begin
                            $display("the queue never reported full during the run");
                            error_count++;
                        end
                        done = 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/100ps

module exec_unit import alu_pkg::*; (
    input  logic               I_clk,
    input  logic               I_reset,
    input  logic               I_push,
    input  logic [ALUOP_W-1:0] I_aluop,
    input  logic [XLEN-1:0]    I_s1,
    input  logic [XLEN-1:0]    I_s2,
    output logic               O_full,
    output logic               O_result_valid,
    output logic [XLEN-1:0]    O_result,
    output logic               O_lt,
    output logic               O_ltu,
    output logic               O_eq
);

    logic [ALUOP_W-1:0] head_aluop;
    logic [XLEN-1:0]    head_s1;
    logic [XLEN-1:0]    head_s2;
    logic               empty;
    logic               pop;
    logic               alu_en;
    logic               alu_done;

    op_queue u_op_queue (
        .I_clk        (I_clk),
        .I_reset      (I_reset),
        .I_push       (I_push),
        .I_aluop      (I_aluop),
        .I_s1         (I_s1),
        .I_s2         (I_s2),
        .I_pop        (pop),
        .O_head_aluop (head_aluop),
        .O_head_s1    (head_s1),
        .O_head_s2    (head_s2),
        .O_empty      (empty),
        .O_full       (O_full)
    );

    issue_ctrl u_issue_ctrl (
        .I_clk          (I_clk),
        .I_reset        (I_reset),
        .I_empty        (empty),
        .I_done         (alu_done),
        .O_en           (alu_en),
        .O_pop          (pop),
        .O_result_valid (O_result_valid)
    );

    alu_core u_alu_core (
        .I_clk   (I_clk),
        .I_reset (I_reset),
        .I_en    (alu_en),
        .I_aluop (head_aluop),
        .I_s1    (head_s1),
        .I_s2    (head_s2),
        .O_done  (alu_done),
        .O_data  (O_result),
        .O_lt    (O_lt),
        .O_ltu   (O_ltu),
        .O_eq    (O_eq)
    );

endmodule

//--- logic/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl (
    input  logic I_clk,
    input  logic I_reset,
    input  logic I_empty,
    input  logic I_done,
    output logic O_en,
    output logic O_pop,
    output logic O_result_valid
);

    // low is idle, high is running with the enable held
    logic running;
    logic finish;

    assign finish = running && I_done;

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            running <= 1'b0;
        end else if (!running) begin
            running <= !I_empty;
        end else if (I_done) begin
            // one idle cycle lets the popped head settle
            running <= 1'b0;
        end
    end

    assign O_en           = running;
    assign O_pop          = finish;
    assign O_result_valid = finish;

endmodule

//--- logic/op_queue.sv
`timescale 1ns/100ps

module op_queue import alu_pkg::*; (
    input  logic               I_clk,
    input  logic               I_reset,
    input  logic               I_push,
    input  logic [ALUOP_W-1:0] I_aluop,
    input  logic [XLEN-1:0]    I_s1,
    input  logic [XLEN-1:0]    I_s2,
    input  logic               I_pop,
    output logic [ALUOP_W-1:0] O_head_aluop,
    output logic [XLEN-1:0]    O_head_s1,
    output logic [XLEN-1:0]    O_head_s2,
    output logic               O_empty,
    output logic               O_full
);

    logic [ALUOP_W-1:0]     aluop_mem [QUEUE_DEPTH];
    logic [XLEN-1:0]        s1_mem    [QUEUE_DEPTH];
    logic [XLEN-1:0]        s2_mem    [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    assign O_empty = (count == '0);
    assign O_full  = (count == QUEUE_CNT_W'(QUEUE_DEPTH));

    // push while full and pop while empty are dropped
    assign do_push = I_push && !O_full;
    assign do_pop  = I_pop && !O_empty;

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + QUEUE_PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + QUEUE_PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + QUEUE_CNT_W'(1);
                2'b01:   count <= count - QUEUE_CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge I_clk) begin
        if (do_push) begin
            aluop_mem[wr_ptr] <= I_aluop;
            s1_mem[wr_ptr]    <= I_s1;
            s2_mem[wr_ptr]    <= I_s2;
        end
    end

    assign O_head_aluop = aluop_mem[rd_ptr];
    assign O_head_s1    = s1_mem[rd_ptr];
    assign O_head_s2    = s2_mem[rd_ptr];

    a_count_bound: assert property (@(posedge I_clk) disable iff (I_reset)
        count <= QUEUE_CNT_W'(QUEUE_DEPTH));

endmodule

//--- alu/alu_core.sv
`timescale 1ns/100ps

module alu_core import alu_pkg::*; (
    input  logic               I_clk,
    input  logic               I_reset,
    input  logic               I_en,
    input  logic [ALUOP_W-1:0] I_aluop,
    input  logic [XLEN-1:0]    I_s1,
    input  logic [XLEN-1:0]    I_s2,
    output logic               O_done,
    output logic [XLEN-1:0]    O_data,
    output logic               O_lt,
    output logic               O_ltu,
    output logic               O_eq
);

    logic [XLEN-1:0]    sum;
    logic [XLEN:0]      diff;
    logic [XLEN-1:0]    res_and;
    logic [XLEN-1:0]    res_or;
    logic [XLEN-1:0]    res_xor;
    logic               lt;
    logic               ltu;
    logic               eq;

    logic               is_shift;
    logic               is_mul;
    logic               start;
    logic               busy;
    logic               shifting;
    logic [SHAMT_W-1:0] shift_cnt;
    logic               done_r;
    logic [XLEN-1:0]    result_r;
    logic               mul_sel;
    logic               mul_hi;

    logic               mul_start;
    logic               mul_s1_signed;
    logic               mul_s2_signed;
    logic               mul_done;
    product_t           mul_product;

    assign sum     = I_s1 + I_s2;
    assign diff    = {1'b0, I_s1} - {1'b0, I_s2};
    assign res_and = I_s1 & I_s2;
    assign res_or  = I_s1 | I_s2;
    assign res_xor = I_s1 ^ I_s2;

    // borrow gives unsigned order, differing signs flip it for signed order
    assign ltu = diff[XLEN];
    assign lt  = diff[XLEN] ^ res_xor[XLEN-1];
    assign eq  = (diff[XLEN-1:0] == '0);

    assign is_shift = (I_aluop == ALUOP_SLL) || (I_aluop == ALUOP_SRL) ||
                      (I_aluop == ALUOP_SRA);
    assign is_mul   = (I_aluop == ALUOP_MUL) || (I_aluop == ALUOP_MULH) ||
                      (I_aluop == ALUOP_MULHSU) || (I_aluop == ALUOP_MULHU);

    // an op is accepted once per rising edge of the enable level
    assign start         = I_en && !busy;
    assign mul_start     = start && is_mul;
    assign mul_s1_signed = (I_aluop == ALUOP_MULH) || (I_aluop == ALUOP_MULHSU);
    assign mul_s2_signed = (I_aluop == ALUOP_MULH);

    alu_mul u_alu_mul (
        .I_clk       (I_clk),
        .I_reset     (I_reset),
        .I_start     (mul_start),
        .I_s1        (I_s1),
        .I_s1_signed (mul_s1_signed),
        .I_s2        (I_s2),
        .I_s2_signed (mul_s2_signed),
        .O_done      (mul_done),
        .O_product   (mul_product)
    );

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            busy      <= 1'b0;
            shifting  <= 1'b0;
            shift_cnt <= '0;
            done_r    <= 1'b0;
            mul_sel   <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (!I_en) begin
                busy <= 1'b0;
            end else if (!busy) begin
                busy      <= 1'b1;
                mul_sel   <= is_mul;
                shift_cnt <= I_s2[SHAMT_W-1:0];
                if (is_shift) begin
                    if (I_s2[SHAMT_W-1:0] == '0) begin
                        done_r <= 1'b1;
                    end else begin
                        shifting <= 1'b1;
                    end
                end else if (!is_mul) begin
                    done_r <= 1'b1;
                end
            end else if (shifting) begin
                shift_cnt <= shift_cnt - SHAMT_W'(1);
                if (shift_cnt == SHAMT_W'(1)) begin
                    shifting <= 1'b0;
                    done_r   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge I_clk) begin
        if (start) begin
            O_lt   <= lt;
            O_ltu  <= ltu;
            O_eq   <= eq;
            mul_hi <= (I_aluop != ALUOP_MUL);
            case (I_aluop)
                ALUOP_SUB:  result_r <= diff[XLEN-1:0];
                ALUOP_AND:  result_r <= res_and;
                ALUOP_OR:   result_r <= res_or;
                ALUOP_XOR:  result_r <= res_xor;
                ALUOP_SLT:  result_r <= XLEN'(lt);
                ALUOP_SLTU: result_r <= XLEN'(ltu);
                ALUOP_SLL, ALUOP_SRL, ALUOP_SRA: result_r <= I_s1;
                default:    result_r <= sum;
            endcase
        end else if (shifting) begin
            case (I_aluop)
                ALUOP_SLL: result_r <= {result_r[XLEN-2:0], 1'b0};
                ALUOP_SRL: result_r <= {1'b0, result_r[XLEN-1:1]};
                default:   result_r <= {result_r[XLEN-1], result_r[XLEN-1:1]};
            endcase
        end
    end

    // multiplier result is read straight from its product register
    assign O_done = done_r || mul_done;
    assign O_data = !mul_sel ? result_r :
                    (mul_hi ? mul_product.half.hi : mul_product.half.lo);

    a_done_single: assert property (@(posedge I_clk) disable iff (I_reset)
        O_done |=> !O_done);

    a_done_after_reset: assert property (@(posedge I_clk)
        I_reset |=> !O_done);

endmodule

//--- alu/alu_mul.sv
`timescale 1ns/100ps

module alu_mul import alu_pkg::*; (
    input  logic            I_clk,
    input  logic            I_reset,
    input  logic            I_start,
    input  logic [XLEN-1:0] I_s1,
    input  logic            I_s1_signed,
    input  logic [XLEN-1:0] I_s2,
    input  logic            I_s2_signed,
    output logic            O_done,
    output product_t        O_product
);

    logic [2*XLEN-1:0] s1_ext;
    logic [2*XLEN-1:0] s2_ext;
    logic [2*XLEN-1:0] mcand;
    logic [XLEN-1:0]   mplier;
    logic              mplier_neg;
    logic [SHAMT_W-1:0] step;
    logic              running;
    logic              done_r;
    logic [2*XLEN-1:0] partial;
    logic              last_step;
    product_t          acc;

    assign s1_ext = I_s1_signed ? {{XLEN{I_s1[XLEN-1]}}, I_s1} : {{XLEN{1'b0}}, I_s1};
    assign s2_ext = I_s2_signed ? {{XLEN{I_s2[XLEN-1]}}, I_s2} : {{XLEN{1'b0}}, I_s2};

    assign partial   = mplier[0] ? mcand : '0;
    assign last_step = (step == SHAMT_W'(XLEN - 1));

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            running <= 1'b0;
            done_r  <= 1'b0;
            step    <= '0;
        end else begin
            done_r <= 1'b0;
            if (I_start) begin
                running <= 1'b1;
                step    <= '0;
            end else if (running) begin
                step <= step + SHAMT_W'(1);
                if (last_step) begin
                    running <= 1'b0;
                    done_r  <= 1'b1;
                end
            end
        end
    end

    // a negative multiplier's top bit weighs -2^31, so the last step subtracts
    always_ff @(posedge I_clk) begin
        if (I_start) begin
            mcand      <= s1_ext;
            mplier     <= s2_ext[XLEN-1:0];
            mplier_neg <= s2_ext[2*XLEN-1];
            acc.full   <= '0;
        end else if (running) begin
            mcand  <= {mcand[2*XLEN-2:0], 1'b0};
            mplier <= {1'b0, mplier[XLEN-1:1]};
            if (last_step && mplier_neg) begin
                acc.full <= acc.full - partial;
            end else begin
                acc.full <= acc.full + partial;
            end
        end
    end

    assign O_done    = done_r;
    assign O_product = acc;

    a_no_restart: assert property (@(posedge I_clk) disable iff (I_reset)
        I_start |-> !running);

endmodule

//--- common/alu_pkg.sv
package alu_pkg;

    localparam int XLEN    = 32;
    localparam int SHAMT_W = 5;
    localparam int ALUOP_W = 4;

    // unlisted op codes 14 and 15 fall through to add
    localparam logic [ALUOP_W-1:0] ALUOP_ADD    = 4'd0;
    localparam logic [ALUOP_W-1:0] ALUOP_SUB    = 4'd1;
    localparam logic [ALUOP_W-1:0] ALUOP_AND    = 4'd2;
    localparam logic [ALUOP_W-1:0] ALUOP_OR     = 4'd3;
    localparam logic [ALUOP_W-1:0] ALUOP_XOR    = 4'd4;
    localparam logic [ALUOP_W-1:0] ALUOP_SLT    = 4'd5;
    localparam logic [ALUOP_W-1:0] ALUOP_SLTU   = 4'd6;
    localparam logic [ALUOP_W-1:0] ALUOP_SLL    = 4'd7;
    localparam logic [ALUOP_W-1:0] ALUOP_SRL    = 4'd8;
    localparam logic [ALUOP_W-1:0] ALUOP_SRA    = 4'd9;
    localparam logic [ALUOP_W-1:0] ALUOP_MUL    = 4'd10;
    localparam logic [ALUOP_W-1:0] ALUOP_MULH   = 4'd11;
    localparam logic [ALUOP_W-1:0] ALUOP_MULHSU = 4'd12;
    localparam logic [ALUOP_W-1:0] ALUOP_MULHU  = 4'd13;

    // request queue depth must be a power of two
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // 64-bit product seen whole or as two words
    typedef union packed {
        logic [2*XLEN-1:0] full;
        struct packed {
            logic [XLEN-1:0] hi;
            logic [XLEN-1:0] lo;
        } half;
    } product_t;

endpackage
